// ==== include/axil_periph_macros.svh ====
`ifndef AXIL_PERIPH_MACROS_SVH
`define AXIL_PERIPH_MACROS_SVH

// ==================================================
// Bus widths
// ==================================================
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

`define NUM_LEDS 4

// ==================================================
// Word indices, address bits 3:2
// ==================================================
`define REG_LED_IDX     2'd0
`define REG_SEG_IDX     2'd1
`define REG_IRQ_IDX     2'd2
`define REG_SCRATCH_IDX 2'd3

// Cycles of disagreement before a new input level is taken
`define DEBOUNCE_CYCLES 16
`define SCAN_CYCLES     8   // Per digit

`define AXIL_RESP_OKAY 2'b00

`endif

// ==== verilog/axil_periph_pkg.sv ====
`include "axil_periph_macros.svh"

package axil_periph_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;    // Byte address
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [1:0]              axil_resp_t;
    typedef logic [1:0]              reg_idx_t;      // Word index

    // Panel side
    typedef logic [`NUM_LEDS-1:0] led_vec_t;
    typedef logic [15:0]          hex_digits_t;      // Digit 0 in the low nibble
    typedef logic [6:0]           seg_pattern_t;     // {g,f,e,d,c,b,a}, active low
    typedef logic [3:0]           anode_vec_t;       // Active low

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_HAVE_ADDR,
        WR_HAVE_DATA,
        WR_COMMIT,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

endpackage

// ==== verilog/irq_debounce.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module irq_debounce
    import axil_periph_pkg::*;
(
    input  logic clk,
    input  logic S_AXI_ARESETN,
    input  logic EXT_IRQ_IN,
    output logic irq_set
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

    logic             sync_1;
    logic             sync_2;
    logic             stable;      // Debounced level
    logic             stable_q;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end else begin
            sync_1 <= EXT_IRQ_IN;
            sync_2 <= sync_1;
        end
    end

    // ==================================================
    // Debounce counter
    // ==================================================
    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            cnt    <= '0;
            stable <= 1'b0;
        end else if (sync_2 == stable) begin
            cnt <= '0;                                  // Glitch over, start again
        end else if (cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
            cnt    <= '0;
            stable <= sync_2;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            stable_q <= 1'b0;
            irq_set  <= 1'b0;
        end else begin
            stable_q <= stable;
            irq_set  <= stable && !stable_q;    // Rising edge only
        end
    end

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!S_AXI_ARESETN)
        irq_set |=> !irq_set
    );

endmodule

// ==== verilog/sevenseg_scan.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module sevenseg_scan
    import axil_periph_pkg::*;
(
    input  logic         clk,
    input  logic         S_AXI_ARESETN,
    input  hex_digits_t  seg_digits,
    output seg_pattern_t SEG_CATHODE,
    output anode_vec_t   SEG_ANODE
);

    localparam int SCAN_W = $clog2(`SCAN_CYCLES);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit_idx;
    logic [3:0]        nibble;

    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            scan_cnt  <= '0;
            digit_idx <= 2'd0;
        end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble    = seg_digits[4*digit_idx +: 4];
    assign SEG_ANODE = ~(anode_vec_t'(1) << digit_idx);    // One-cold

    // ==================================================
    // Hex decode, common anode
    // ==================================================
    always_comb begin
        case (nibble)
            4'h0: SEG_CATHODE = 7'b1000000;
            4'h1: SEG_CATHODE = 7'b1111001;
            4'h2: SEG_CATHODE = 7'b0100100;
            4'h3: SEG_CATHODE = 7'b0110000;
            4'h4: SEG_CATHODE = 7'b0011001;
            4'h5: SEG_CATHODE = 7'b0010010;
            4'h6: SEG_CATHODE = 7'b0000010;
            4'h7: SEG_CATHODE = 7'b1111000;
            4'h8: SEG_CATHODE = 7'b0000000;
            4'h9: SEG_CATHODE = 7'b0010000;
            4'hA: SEG_CATHODE = 7'b0001000;
            4'hB: SEG_CATHODE = 7'b0000011;    // Lowercase b
            4'hC: SEG_CATHODE = 7'b1000110;
            4'hD: SEG_CATHODE = 7'b0100001;    // Lowercase d
            4'hE: SEG_CATHODE = 7'b0000110;
            default: SEG_CATHODE = 7'b0001110;
        endcase
    end

    a_one_digit: assert property (
        @(posedge clk) disable iff (!S_AXI_ARESETN)
        $onehot(~SEG_ANODE)
    );

endmodule

// ==== verilog/periph_regs.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module periph_regs
    import axil_periph_pkg::*;
(
    input  logic        clk,
    input  logic        S_AXI_ARESETN,
    input  logic        reg_wr_en,
    input  axil_addr_t  reg_wr_addr,
    input  axil_data_t  reg_wr_data,
    input  axil_strb_t  reg_wr_strb,
    input  logic        reg_rd_en,
    input  axil_addr_t  reg_rd_addr,
    input  logic        irq_set,
    output axil_data_t  reg_rd_data,
    output logic        reg_rd_valid,
    output led_vec_t    LED,
    output hex_digits_t seg_digits,
    output logic        IRQ_OUT
);

    axil_data_t reg_led;
    axil_data_t reg_seg;
    axil_data_t reg_scratch;
    logic       irq_status;
    reg_idx_t   wr_idx;
    reg_idx_t   rd_idx;
    logic       irq_clr;

    // Only the strobed bytes of wdata replace the current word
    function automatic axil_data_t merge_strb(axil_data_t cur, axil_data_t wdata,
                                              axil_strb_t strb);
        axil_data_t res;
        res = cur;
        for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr_idx  = reg_wr_addr[3:2];
    assign rd_idx  = reg_rd_addr[3:2];
    assign irq_clr = reg_wr_en && wr_idx == `REG_IRQ_IDX && reg_wr_strb[0] && reg_wr_data[0];

    // ==================================================
    // Register writes
    // ==================================================
    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            reg_led     <= '0;
            reg_seg     <= '0;
            reg_scratch <= '0;
            irq_status  <= 1'b0;
            LED         <= '0;
        end else begin
            if (reg_wr_en && wr_idx == `REG_LED_IDX) begin
                reg_led <= merge_strb(reg_led, reg_wr_data, reg_wr_strb);
            end
            if (reg_wr_en && wr_idx == `REG_SEG_IDX) begin
                reg_seg <= merge_strb(reg_seg, reg_wr_data, reg_wr_strb);
            end
            if (reg_wr_en && wr_idx == `REG_SCRATCH_IDX) begin
                reg_scratch <= merge_strb(reg_scratch, reg_wr_data, reg_wr_strb);
            end
            if (irq_clr) begin
                irq_status <= 1'b0;       // Clear beats a same-cycle set
            end else if (irq_set) begin
                irq_status <= 1'b1;
            end
            LED <= reg_led[`NUM_LEDS-1:0];
        end
    end

    // Read data one cycle after the request
    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            case (rd_idx)
                `REG_LED_IDX: reg_rd_data <= reg_led;
                `REG_SEG_IDX: reg_rd_data <= reg_seg;
                `REG_IRQ_IDX: reg_rd_data <= {{(`AXIL_DATA_W-1){1'b0}}, irq_status};
                default:      reg_rd_data <= reg_scratch;
            endcase
        end
    end

    assign seg_digits = reg_seg[15:0];
    assign IRQ_OUT    = irq_status;

endmodule

// ==== verilog/axil_read_ctrl.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module axil_read_ctrl
    import axil_periph_pkg::*;
(
    input  logic       clk,
    input  logic       S_AXI_ARESETN,
    input  axil_addr_t S_AXI_ARADDR,
    input  logic       S_AXI_ARVALID,
    output logic       S_AXI_ARREADY,
    output axil_data_t S_AXI_RDATA,
    output axil_resp_t S_AXI_RRESP,
    output logic       S_AXI_RVALID,
    input  logic       S_AXI_RREADY,
    output logic       reg_rd_en,
    output axil_addr_t reg_rd_addr,
    input  axil_data_t reg_rd_data,
    input  logic       reg_rd_valid
);

    rd_state_t state;
    logic      ar_hs;
    logic      req_pend;    // Address taken, request goes out next cycle

    assign ar_hs       = S_AXI_ARVALID && S_AXI_ARREADY;
    assign S_AXI_RRESP = `AXIL_RESP_OKAY;

    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state         <= RD_IDLE;
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
            req_pend      <= 1'b0;
            reg_rd_en     <= 1'b0;
        end else begin
            req_pend  <= ar_hs;
            reg_rd_en <= req_pend;
            case (state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        S_AXI_ARREADY <= 1'b0;
                        state         <= RD_WAIT;
                    end else begin
                        S_AXI_ARREADY <= 1'b1;
                    end
                end
                RD_WAIT: begin
                    if (reg_rd_valid) begin
                        S_AXI_RVALID <= 1'b1;
                        state        <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (S_AXI_RREADY) begin
                        S_AXI_RVALID <= 1'b0;
                        state        <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            reg_rd_addr <= S_AXI_ARADDR;
        end
        if (state == RD_WAIT && reg_rd_valid) begin
            S_AXI_RDATA <= reg_rd_data;    // Held until RREADY
        end
    end

    a_rdata_stable: assert property (
        @(posedge clk) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA)
    );

endmodule

// ==== verilog/axil_write_ctrl.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module axil_write_ctrl
    import axil_periph_pkg::*;
(
    input  logic       clk,
    input  logic       S_AXI_ARESETN,
    input  axil_addr_t S_AXI_AWADDR,
    input  logic       S_AXI_AWVALID,
    output logic       S_AXI_AWREADY,
    input  axil_data_t S_AXI_WDATA,
    input  axil_strb_t S_AXI_WSTRB,
    input  logic       S_AXI_WVALID,
    output logic       S_AXI_WREADY,
    output axil_resp_t S_AXI_BRESP,
    output logic       S_AXI_BVALID,
    input  logic       S_AXI_BREADY,
    output logic       reg_wr_en,
    output axil_addr_t reg_wr_addr,
    output axil_data_t reg_wr_data,
    output axil_strb_t reg_wr_strb
);

    wr_state_t state;
    logic      aw_hs;
    logic      w_hs;

    assign aw_hs       = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_hs        = S_AXI_WVALID && S_AXI_WREADY;
    assign S_AXI_BRESP = `AXIL_RESP_OKAY;

    // ==================================================
    // Write FSM
    // ==================================================
    always_ff @(posedge clk or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state         <= WR_IDLE;
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
            reg_wr_en     <= 1'b0;
        end else begin
            reg_wr_en <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (aw_hs && w_hs) begin
                        S_AXI_AWREADY <= 1'b0;
                        S_AXI_WREADY  <= 1'b0;
                        state         <= WR_COMMIT;
                    end else if (aw_hs) begin
                        S_AXI_AWREADY <= 1'b0;    // Data still pending
                        state         <= WR_HAVE_ADDR;
                    end else if (w_hs) begin
                        S_AXI_WREADY  <= 1'b0;    // Address still pending
                        state         <= WR_HAVE_DATA;
                    end else begin
                        S_AXI_AWREADY <= 1'b1;
                        S_AXI_WREADY  <= 1'b1;
                    end
                end
                WR_HAVE_ADDR: begin
                    if (w_hs) begin
                        S_AXI_WREADY <= 1'b0;
                        state        <= WR_COMMIT;
                    end
                end
                WR_HAVE_DATA: begin
                    if (aw_hs) begin
                        S_AXI_AWREADY <= 1'b0;
                        state         <= WR_COMMIT;
                    end
                end
                WR_COMMIT: begin
                    reg_wr_en    <= 1'b1;         // Register updates with BVALID high
                    S_AXI_BVALID <= 1'b1;
                    state        <= WR_RESP;
                end
                WR_RESP: begin
                    if (S_AXI_BREADY) begin
                        S_AXI_BVALID <= 1'b0;
                        state        <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Captured address, data and strobes
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            reg_wr_addr <= S_AXI_AWADDR;
        end
        if (w_hs) begin
            reg_wr_data <= S_AXI_WDATA;
            reg_wr_strb <= S_AXI_WSTRB;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID
    );

endmodule

// ==== verilog/axil_periph_top.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module axil_periph_top
    import axil_periph_pkg::*;
(
    input  logic         clk,
    input  logic         S_AXI_ARESETN,
    // Write channels
    input  axil_addr_t   S_AXI_AWADDR,
    input  logic         S_AXI_AWVALID,
    output logic         S_AXI_AWREADY,
    input  axil_data_t   S_AXI_WDATA,
    input  axil_strb_t   S_AXI_WSTRB,
    input  logic         S_AXI_WVALID,
    output logic         S_AXI_WREADY,
    output axil_resp_t   S_AXI_BRESP,
    output logic         S_AXI_BVALID,
    input  logic         S_AXI_BREADY,
    // Read channels
    input  axil_addr_t   S_AXI_ARADDR,
    input  logic         S_AXI_ARVALID,
    output logic         S_AXI_ARREADY,
    output axil_data_t   S_AXI_RDATA,
    output axil_resp_t   S_AXI_RRESP,
    output logic         S_AXI_RVALID,
    input  logic         S_AXI_RREADY,
    // Front panel
    input  logic         EXT_IRQ_IN,
    output led_vec_t     LED,
    output seg_pattern_t SEG_CATHODE,
    output anode_vec_t   SEG_ANODE,
    output logic         IRQ_OUT
);

    logic        reg_wr_en;
    axil_addr_t  reg_wr_addr;
    axil_data_t  reg_wr_data;
    axil_strb_t  reg_wr_strb;
    logic        reg_rd_en;
    axil_addr_t  reg_rd_addr;
    axil_data_t  reg_rd_data;
    logic        reg_rd_valid;
    logic        irq_set;
    hex_digits_t seg_digits;

    // ==================================================
    // Bus side
    // ==================================================
    axil_write_ctrl u_write_ctrl (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .reg_wr_en     (reg_wr_en),
        .reg_wr_addr   (reg_wr_addr),
        .reg_wr_data   (reg_wr_data),
        .reg_wr_strb   (reg_wr_strb)
    );

    axil_read_ctrl u_read_ctrl (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .reg_rd_en     (reg_rd_en),
        .reg_rd_addr   (reg_rd_addr),
        .reg_rd_data   (reg_rd_data),
        .reg_rd_valid  (reg_rd_valid)
    );

    periph_regs u_regs (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr_en     (reg_wr_en),
        .reg_wr_addr   (reg_wr_addr),
        .reg_wr_data   (reg_wr_data),
        .reg_wr_strb   (reg_wr_strb),
        .reg_rd_en     (reg_rd_en),
        .reg_rd_addr   (reg_rd_addr),
        .irq_set       (irq_set),
        .reg_rd_data   (reg_rd_data),
        .reg_rd_valid  (reg_rd_valid),
        .LED           (LED),
        .seg_digits    (seg_digits),
        .IRQ_OUT       (IRQ_OUT)
    );

    // Panel side
    irq_debounce u_irq_debounce (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .EXT_IRQ_IN    (EXT_IRQ_IN),
        .irq_set       (irq_set)
    );

    sevenseg_scan u_sevenseg (
        .clk           (clk),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .seg_digits    (seg_digits),
        .SEG_CATHODE   (SEG_CATHODE),
        .SEG_ANODE     (SEG_ANODE)
    );

endmodule

// ==== tb/tb_axil_periph.sv ====
`timescale 1ns/1ps
`include "axil_periph_macros.svh"

module tb_axil_periph
    import axil_periph_pkg::*;
();

    localparam int ORDER_BOTH     = 0;
    localparam int ORDER_AW_FIRST = 1;
    localparam int ORDER_W_FIRST  = 2;
    localparam int TEST_CYCLES    = 5000;              // Upper estimate of all sections
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    // Common anode {g,f,e,d,c,b,a}, digits 0 to F
    localparam logic [6:0] HEX_SEGS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    logic         clk;
    logic         S_AXI_ARESETN;
    axil_addr_t   S_AXI_AWADDR;
    logic         S_AXI_AWVALID;
    logic         S_AXI_AWREADY;
    axil_data_t   S_AXI_WDATA;
    axil_strb_t   S_AXI_WSTRB;
    logic         S_AXI_WVALID;
    logic         S_AXI_WREADY;
    axil_resp_t   S_AXI_BRESP;
    logic         S_AXI_BVALID;
    logic         S_AXI_BREADY;
    axil_addr_t   S_AXI_ARADDR;
    logic         S_AXI_ARVALID;
    logic         S_AXI_ARREADY;
    axil_data_t   S_AXI_RDATA;
    axil_resp_t   S_AXI_RRESP;
    logic         S_AXI_RVALID;
    logic         S_AXI_RREADY;
    logic         EXT_IRQ_IN;
    led_vec_t     LED;
    seg_pattern_t SEG_CATHODE;
    anode_vec_t   SEG_ANODE;
    logic         IRQ_OUT;

    int         value_errs = 0;
    int         other_errs = 0;
    int         cycle_cnt  = 0;
    integer     seed;
    axil_data_t model [4];    // Expected register words
    logic       ar_fire;

    axil_periph_top uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==================================================
    // Handshake checks
    // ==================================================
    assign ar_fire = S_AXI_ARVALID && S_AXI_ARREADY;

    a_b_hold: assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
        else begin
            other_errs++;
            $display("BVALID dropped before the response was accepted");
        end

    a_r_hold: assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
        else begin
            other_errs++;
            $display("RVALID dropped or RDATA changed while RREADY was low");
        end

    // RVALID set by the third edge after the AR transfer, seen one sample later
    a_r_late: assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        $rose(S_AXI_RVALID) |-> $past(ar_fire, 4))
        else begin
            other_errs++;
            $display("RVALID rose at a different distance from the AR transfer");
        end

    a_r_due: assert property (@(posedge clk) disable iff (!S_AXI_ARESETN)
        $past(ar_fire, 4) |-> $rose(S_AXI_RVALID))
        else begin
            other_errs++;
            $display("RVALID did not rise three edges after the AR transfer");
        end

    function automatic axil_data_t byte_mask(input axil_strb_t strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    task automatic check_value(input string name, input axil_data_t exp, input axil_data_t act);
        assert (act == exp) else begin
            value_errs++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act == exp) else begin
            value_errs++;
            $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // ==================================================
    // Bus tasks
    // ==================================================
    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb, input int order);
        logic aw_sent;
        logic w_sent;
        logic aw_fire;
        logic w_fire;
        int   stall;
        aw_sent = 1'b0;
        w_sent  = 1'b0;
        stall   = $unsigned($random(seed)) % 5;
        @(negedge clk);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_AWVALID = (order != ORDER_W_FIRST);
        S_AXI_WVALID  = (order != ORDER_AW_FIRST);
        while (!(aw_sent && w_sent)) begin
            aw_fire = S_AXI_AWVALID && S_AXI_AWREADY;
            w_fire  = S_AXI_WVALID && S_AXI_WREADY;
            @(negedge clk);
            if (aw_fire) begin
                S_AXI_AWVALID = 1'b0;
                aw_sent       = 1'b1;
            end
            if (w_fire) begin
                S_AXI_WVALID = 1'b0;
                w_sent       = 1'b1;
            end
            // Split write, second channel follows the first
            if (aw_sent && !w_sent) begin
                S_AXI_WVALID = 1'b1;
            end
            if (w_sent && !aw_sent) begin
                S_AXI_AWVALID = 1'b1;
            end
        end
        while (!S_AXI_BVALID) begin
            @(negedge clk);
        end
        repeat (stall) @(negedge clk);    // BREADY held low
        check_value("write BRESP", axil_data_t'(`AXIL_RESP_OKAY), axil_data_t'(S_AXI_BRESP));
        S_AXI_BREADY = 1'b1;
        @(negedge clk);
        S_AXI_BREADY = 1'b0;
        if (addr[3:2] != `REG_IRQ_IDX) begin
            model[addr[3:2]] = (model[addr[3:2]] & ~byte_mask(strb)) | (data & byte_mask(strb));
        end
    endtask

    task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
        int stall;
        stall = $unsigned($random(seed)) % 6;
        @(negedge clk);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        while (!S_AXI_ARREADY) begin
            @(negedge clk);
        end
        @(negedge clk);
        S_AXI_ARVALID = 1'b0;
        while (!S_AXI_RVALID) begin
            @(negedge clk);
        end
        repeat (stall) @(negedge clk);
        data = S_AXI_RDATA;
        check_value("read RRESP", axil_data_t'(`AXIL_RESP_OKAY), axil_data_t'(S_AXI_RRESP));
        S_AXI_RREADY = 1'b1;
        @(negedge clk);
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic read_expect(input axil_addr_t addr, input axil_data_t exp, input string name);
        axil_data_t got;
        axi_read(addr, got);
        check_value(name, exp, got);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        axil_data_t wdata;
        axil_strb_t strb;
        axil_addr_t addr;
        anode_vec_t pattern;
        logic [3:0] nib;
        int         idx;
        int         order;
        int         wait_cnt;
        axil_addr_t reg_addrs [3];
        axil_strb_t strb_list [6];
        seed          = 32'hebdf_4322;
        reg_addrs     = '{4'h0, 4'h4, 4'hC};
        strb_list     = '{4'b0001, 4'b0110, 4'b1000, 4'b0101, 4'b0000, 4'b1010};
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        EXT_IRQ_IN    = 1'b0;
        for (int i = 0; i < 4; i++) begin
            model[i] = '0;
        end

        // Reset
        repeat (4) @(negedge clk);
        S_AXI_ARESETN = 1'b1;
        check_bit("reset BVALID", 1'b0, S_AXI_BVALID);
        check_bit("reset RVALID", 1'b0, S_AXI_RVALID);
        check_bit("reset IRQ_OUT", 1'b0, IRQ_OUT);
        check_value("reset LED", 32'h0, axil_data_t'(LED));
        check_value("reset SEG_ANODE", 32'hE, axil_data_t'(SEG_ANODE));
        repeat (2) @(negedge clk);
        check_bit("reset AWREADY", 1'b1, S_AXI_AWREADY);
        check_bit("reset WREADY", 1'b1, S_AXI_WREADY);
        check_bit("reset ARREADY", 1'b1, S_AXI_ARREADY);

        // Every register with every ordering
        for (int r = 0; r < 3; r++) begin
            for (int o = 0; o < 3; o++) begin
                axi_write(reg_addrs[r], $random(seed), 4'hF, o);
                read_expect(reg_addrs[r], model[reg_addrs[r][3:2]],
                            $sformatf("readback 0x%0h order %0d", reg_addrs[r], o));
            end
        end

        // Partial strobes on scratch
        for (int s = 0; s < 6; s++) begin
            axi_write(4'hC, $random(seed), strb_list[s], s % 3);
            read_expect(4'hC, model[`REG_SCRATCH_IDX], $sformatf("strobe %04b", strb_list[s]));
        end

        // Mixed traffic, random back-pressure in every task
        for (int n = 0; n < 12; n++) begin
            idx   = $unsigned($random(seed)) % 3;
            idx   = (idx == 2) ? 3 : idx;    // Status register left alone
            order = $unsigned($random(seed)) % 3;
            addr  = axil_addr_t'(idx << 2);
            wdata = $random(seed);
            strb  = axil_strb_t'($random(seed));
            axi_write(addr, wdata, strb, order);
            read_expect(addr, model[idx], $sformatf("mixed %0d at 0x%0h", n, addr));
        end

        // LED outputs
        for (int n = 0; n < 3; n++) begin
            axi_write(4'h0, $random(seed), 4'hF, ORDER_BOTH);
            @(negedge clk);
            check_value("LED", axil_data_t'(model[`REG_LED_IDX][3:0]), axil_data_t'(LED));
        end

        // Display, all sixteen hex values over four words
        for (int w = 0; w < 4; w++) begin
            wdata[31:16] = 16'($random(seed));
            wdata[15:0]  = {4'(4*w + 3), 4'(4*w + 2), 4'(4*w + 1), 4'(4*w)};
            axi_write(4'h4, wdata, 4'hF, ORDER_BOTH);
            for (int d = 0; d < 4; d++) begin
                pattern = ~(anode_vec_t'(1) << d);
                while (SEG_ANODE != pattern) begin
                    @(negedge clk);
                end
                nib = model[`REG_SEG_IDX][4*d +: 4];
                check_value($sformatf("segments word %0d digit %0d", w, d),
                            axil_data_t'(HEX_SEGS[nib]), axil_data_t'(SEG_CATHODE));
            end
        end

        // ==================================================
        // Interrupt
        // ==================================================
        @(negedge clk);
        EXT_IRQ_IN = 1'b1;
        repeat (`DEBOUNCE_CYCLES - 6) @(negedge clk);
        EXT_IRQ_IN = 1'b0;
        repeat (`DEBOUNCE_CYCLES + 5) @(negedge clk);
        check_bit("short pulse IRQ_OUT", 1'b0, IRQ_OUT);
        read_expect(4'h8, 32'h0, "short pulse status");

        EXT_IRQ_IN = 1'b1;
        wait_cnt   = 0;
        while (!IRQ_OUT && wait_cnt < `DEBOUNCE_CYCLES + 5) begin
            @(negedge clk);
            wait_cnt++;
        end
        assert (IRQ_OUT) else begin
            other_errs++;
            $display("IRQ_OUT did not rise within %0d cycles of a steady high input",
                     `DEBOUNCE_CYCLES + 5);
        end
        read_expect(4'h8, 32'h1, "irq status set");
        axi_write(4'h8, 32'h0, 4'hF, ORDER_BOTH);
        read_expect(4'h8, 32'h1, "irq write 0 keeps status");
        check_bit("irq write 0 IRQ_OUT", 1'b1, IRQ_OUT);
        axi_write(4'h8, 32'h1, 4'hF, ORDER_AW_FIRST);
        read_expect(4'h8, 32'h0, "irq write 1 clears status");
        check_bit("irq write 1 IRQ_OUT", 1'b0, IRQ_OUT);
        EXT_IRQ_IN = 1'b0;
        repeat (`DEBOUNCE_CYCLES + 5) @(negedge clk);
        check_bit("irq falling input IRQ_OUT", 1'b0, IRQ_OUT);

        $display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== axil_periph_top.f ====
+incdir+include
verilog/axil_periph_pkg.sv
verilog/irq_debounce.sv
verilog/sevenseg_scan.sv
verilog/periph_regs.sv
verilog/axil_read_ctrl.sv
verilog/axil_write_ctrl.sv
verilog/axil_periph_top.sv
tb/tb_axil_periph.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Iinclude
TOP       = tb_axil_periph
FILELIST  = axil_periph_top.f
RTL_TOP   = axil_periph_top
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

# Static checks of the RTL top level and of the testbench
lint:
	$(VERILATOR) --lint-only --timing --assert -Iinclude -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -Iinclude -f $(FILELIST) --top-module $(TOP)

# Build, run, and decide pass or fail from the log
sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
